//--- compile.f
eth_mac_pkg.sv
eth_crc32.sv
eth_mac_mii_tx.sv
eth_mac_mii_rx.sv
eth_frame_fifo.sv
eth_mac_mii_fifo.sv
tb_eth_mac_mii_fifo.sv

//--- eth_crc32.sv
`timescale 1ns/1ps

module eth_crc32 (
    input  logic        logic_clk,
    input  logic        logic_rst,
    input  logic        init,
    input  logic        nibble_valid,
    input  logic [3:0]  nibble,
    output logic [31:0] crc
);
    import eth_mac_pkg::*;

    // Fold four bits in, LSB first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [3:0] n);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 4; i++) begin
            r = (r >> 1) ^ ((r[0] ^ n[i]) ? CRC_POLY : 32'h0);
        end
        return r;
    endfunction

    logic [31:0] crc_base;

    // A nibble in the init cycle starts from the init value
    assign crc_base = init ? CRC_INIT : crc;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            crc <= CRC_INIT;
        end else if (nibble_valid) begin
            crc <= crc_step(crc_base, nibble);
        end else if (init) begin
            crc <= CRC_INIT;
        end
    end

endmodule

//--- eth_frame_fifo.sv
`timescale 1ns/1ps

module eth_frame_fifo #(
    parameter int DEPTH = 256,
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    input  logic                      logic_clk,
    input  logic                      logic_rst,
    input  eth_mac_pkg::axis_byte_t   s_axis,
    input  logic                      s_axis_valid,
    output logic                      s_axis_ready,
    output eth_mac_pkg::axis_byte_t   m_axis,
    output logic                      m_axis_valid,
    input  logic                      m_axis_ready,
    output eth_mac_pkg::fifo_status_t status
);
    import eth_mac_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);
    localparam logic [ADDR_W:0] PTR_FULL = {1'b1, {ADDR_W{1'b0}}};

    axis_byte_t      mem [DEPTH];
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] wr_ptr_n;
    logic [ADDR_W:0] commit_ptr;
    logic [ADDR_W:0] commit_ptr_n;
    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] rd_ptr_n;
    logic            drop_frame;
    logic            drop_n;
    logic            full;
    logic            wr_en;
    logic            rd_load;
    fifo_status_t    status_n;

    assign full = ((wr_ptr - rd_ptr) == PTR_FULL);
    // Reader only sees committed bytes
    assign rd_load = (rd_ptr != commit_ptr) && (!m_axis_valid || m_axis_ready);

    always_comb begin
        wr_ptr_n = wr_ptr;
        commit_ptr_n = commit_ptr;
        rd_ptr_n = rd_ptr;
        drop_n = drop_frame;
        status_n = '0;
        wr_en = 1'b0;
        if (s_axis_valid && s_axis_ready) begin
            if (drop_frame || full) begin
                drop_n = 1'b1;
                if (s_axis.last) begin
                    wr_ptr_n = commit_ptr;
                    drop_n = 1'b0;
                    status_n.overflow = 1'b1;
                end
            end else begin
                wr_en = 1'b1;
                wr_ptr_n = wr_ptr + 1'b1;
                if (s_axis.last && s_axis.user) begin
                    wr_ptr_n = commit_ptr;
                    status_n.bad_frame = 1'b1;
                end else if (s_axis.last) begin
                    commit_ptr_n = wr_ptr + 1'b1;
                    status_n.good_frame = 1'b1;
                end
            end
        end
        if (rd_load) begin
            rd_ptr_n = rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= s_axis;
        end
        if (rd_load) begin
            m_axis <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr <= '0;
            commit_ptr <= '0;
            rd_ptr <= '0;
            drop_frame <= 1'b0;
            m_axis_valid <= 1'b0;
            s_axis_ready <= 1'b0;
            status <= '0;
        end else begin
            wr_ptr <= wr_ptr_n;
            commit_ptr <= commit_ptr_n;
            rd_ptr <= rd_ptr_n;
            drop_frame <= drop_n;
            status <= status_n;
            s_axis_ready <= DROP_WHEN_FULL ? 1'b1 : ((wr_ptr_n - rd_ptr_n) != PTR_FULL);
            if (rd_load) begin
                m_axis_valid <= 1'b1;
            end else if (m_axis_ready) begin
                m_axis_valid <= 1'b0;
            end
        end
    end

    assert property (@(posedge logic_clk) disable iff (logic_rst) $onehot0(status))
        else $error("FIFO status pulses overlap");

    // Frame filling the whole FIFO can never commit
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (!DROP_WHEN_FULL && s_axis_valid && full) |-> (commit_ptr != rd_ptr))
        else $error("frame longer than FIFO depth");

endmodule

//--- eth_mac_mii_fifo.sv
`timescale 1ns/1ps

module eth_mac_mii_fifo #(
    parameter int MIN_FRAME_LENGTH = 64,
    parameter bit ENABLE_PADDING = 1'b1,
    parameter int TX_FIFO_DEPTH = 256,
    parameter int RX_FIFO_DEPTH = 256,
    parameter bit RX_DROP_WHEN_FULL = 1'b1
) (
    input  logic                     logic_clk,
    input  logic                     logic_rst,
    input  eth_mac_pkg::axis_byte_t  tx_axis,
    input  logic                     tx_axis_valid,
    output logic                     tx_axis_ready,
    output eth_mac_pkg::axis_byte_t  rx_axis,
    output logic                     rx_axis_valid,
    input  logic                     rx_axis_ready,
    output eth_mac_pkg::mii_nibble_t mii_tx,
    input  eth_mac_pkg::mii_nibble_t mii_rx,
    input  logic [7:0]               ifg_delay,
    output eth_mac_pkg::mac_status_t status
);
    import eth_mac_pkg::*;

    axis_byte_t   tx_fifo_axis;
    logic         tx_fifo_valid;
    logic         tx_fifo_ready;
    axis_byte_t   rx_mac_axis;
    logic         rx_mac_valid;
    logic         rx_bad_frame;
    logic         rx_bad_fcs;
    fifo_status_t tx_fifo_status;
    fifo_status_t rx_fifo_status;

    assign status = '{
        tx_fifo: tx_fifo_status,
        rx_error_bad_frame: rx_bad_frame,
        rx_error_bad_fcs: rx_bad_fcs,
        rx_fifo: rx_fifo_status
    };

    // TX side holds whole frames and stalls the user when full
    eth_frame_fifo #(
        .DEPTH          (TX_FIFO_DEPTH),
        .DROP_WHEN_FULL (1'b0)
    ) u_tx_fifo (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .s_axis       (tx_axis),
        .s_axis_valid (tx_axis_valid),
        .s_axis_ready (tx_axis_ready),
        .m_axis       (tx_fifo_axis),
        .m_axis_valid (tx_fifo_valid),
        .m_axis_ready (tx_fifo_ready),
        .status       (tx_fifo_status)
    );

    eth_mac_mii_tx #(
        .MIN_FRAME_LENGTH (MIN_FRAME_LENGTH),
        .ENABLE_PADDING   (ENABLE_PADDING)
    ) u_tx_mac (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .s_axis       (tx_fifo_axis),
        .s_axis_valid (tx_fifo_valid),
        .s_axis_ready (tx_fifo_ready),
        .mii_tx       (mii_tx),
        .ifg_delay    (ifg_delay)
    );

    eth_mac_mii_rx u_rx_mac (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .mii_rx       (mii_rx),
        .m_axis       (rx_mac_axis),
        .m_axis_valid (rx_mac_valid),
        .bad_frame    (rx_bad_frame),
        .bad_fcs      (rx_bad_fcs)
    );

    // MII cannot stall so the RX FIFO ready is left open
    eth_frame_fifo #(
        .DEPTH          (RX_FIFO_DEPTH),
        .DROP_WHEN_FULL (RX_DROP_WHEN_FULL)
    ) u_rx_fifo (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .s_axis       (rx_mac_axis),
        .s_axis_valid (rx_mac_valid),
        .s_axis_ready (),
        .m_axis       (rx_axis),
        .m_axis_valid (rx_axis_valid),
        .m_axis_ready (rx_axis_ready),
        .status       (rx_fifo_status)
    );

endmodule

//--- eth_mac_mii_rx.sv
`timescale 1ns/1ps

module eth_mac_mii_rx (
    input  logic                     logic_clk,
    input  logic                     logic_rst,
    input  eth_mac_pkg::mii_nibble_t mii_rx,
    output eth_mac_pkg::axis_byte_t  m_axis,
    output logic                     m_axis_valid,
    output logic                     bad_frame,
    output logic                     bad_fcs
);
    import eth_mac_pkg::*;

    logic        in_frame;
    logic        phase;
    logic [3:0]  low_nib;
    logic [7:0]  cur_byte;
    logic        cur_valid;
    logic [7:0]  byte_buf [4];
    logic [2:0]  buf_cnt;
    logic        err_seen;
    logic        crc_init;
    logic        crc_valid;
    logic [31:0] crc;
    logic        shift;
    logic        frame_end;
    logic        fcs_ok;
    logic        too_short;

    assign crc_init = !in_frame && mii_rx.en && (mii_rx.d == SFD_NIBBLE);
    assign crc_valid = in_frame && mii_rx.en;

    // A fresh low nibble proves the held byte is not the last one
    assign shift = in_frame && mii_rx.en && !phase && cur_valid;
    assign frame_end = in_frame && !mii_rx.en;

    assign fcs_ok = (crc == CRC_RESIDUE);
    // Needs at least one data byte ahead of the FCS
    assign too_short = (buf_cnt != 3'd4);

    eth_crc32 u_crc (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .init         (crc_init),
        .nibble_valid (crc_valid),
        .nibble       (mii_rx.d),
        .crc          (crc)
    );

    always_ff @(posedge logic_clk) begin
        if (crc_valid && !phase) begin
            low_nib <= mii_rx.d;
        end
        if (crc_valid && phase) begin
            cur_byte <= {mii_rx.d, low_nib};
        end
        if (shift) begin
            byte_buf[0] <= cur_byte;
            for (int i = 1; i < 4; i++) begin
                byte_buf[i] <= byte_buf[i-1];
            end
            m_axis.data <= byte_buf[3];
            m_axis.last <= 1'b0;
            m_axis.user <= 1'b0;
        end else if (frame_end) begin
            // Oldest buffered byte is the last data byte
            m_axis.data <= byte_buf[3];
            m_axis.last <= 1'b1;
            m_axis.user <= err_seen || !fcs_ok;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            in_frame <= 1'b0;
            phase <= 1'b0;
            cur_valid <= 1'b0;
            buf_cnt <= '0;
            err_seen <= 1'b0;
            m_axis_valid <= 1'b0;
            bad_frame <= 1'b0;
            bad_fcs <= 1'b0;
        end else begin
            m_axis_valid <= 1'b0;
            bad_frame <= 1'b0;
            bad_fcs <= 1'b0;

            if (!mii_rx.en) begin
                err_seen <= 1'b0;
            end else if (mii_rx.er) begin
                err_seen <= 1'b1;
            end

            if (crc_init) begin
                in_frame <= 1'b1;
                phase <= 1'b0;
                cur_valid <= 1'b0;
                buf_cnt <= '0;
            end

            if (crc_valid) begin
                phase <= ~phase;
                if (phase) begin
                    cur_valid <= 1'b1;
                end
                if (shift) begin
                    m_axis_valid <= (buf_cnt == 3'd4);
                    if (buf_cnt != 3'd4) begin
                        buf_cnt <= buf_cnt + 3'd1;
                    end
                end
            end

            if (frame_end) begin
                in_frame <= 1'b0;
                m_axis_valid <= !too_short;
                bad_frame <= err_seen || too_short;
                bad_fcs <= !err_seen && !too_short && !fcs_ok;
            end
        end
    end

endmodule

//--- eth_mac_mii_tx.sv
`timescale 1ns/1ps

module eth_mac_mii_tx #(
    parameter int MIN_FRAME_LENGTH = 64,
    parameter bit ENABLE_PADDING = 1'b1
) (
    input  logic                     logic_clk,
    input  logic                     logic_rst,
    input  eth_mac_pkg::axis_byte_t  s_axis,
    input  logic                     s_axis_valid,
    output logic                     s_axis_ready,
    output eth_mac_pkg::mii_nibble_t mii_tx,
    input  logic [7:0]               ifg_delay
);
    import eth_mac_pkg::*;

    // Bytes ahead of the FCS, padding included
    localparam logic [15:0] PAD_BYTES = 16'(MIN_FRAME_LENGTH - 4);
    localparam logic [8:0] IFG_FLOOR = 9'd24;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA,
        ST_PAD,
        ST_FCS,
        ST_GAP
    } tx_state_t;

    tx_state_t   state;
    logic [3:0]  cnt;
    logic        phase;
    logic [15:0] byte_cnt;
    logic [15:0] byte_cnt_inc;
    logic [8:0]  gap_cnt;
    logic [8:0]  gap_len;
    logic [7:0]  data_reg;
    logic        last_reg;
    logic        user_reg;
    logic        take;
    logic        crc_init;
    logic        crc_valid;
    logic [31:0] crc;

    assign s_axis_ready = (state == ST_IDLE) || (state == ST_DATA && phase && !last_reg);
    assign take = s_axis_valid && s_axis_ready;

    assign byte_cnt_inc = (byte_cnt == 16'hffff) ? byte_cnt : byte_cnt + 16'd1;
    assign gap_len = ({ifg_delay, 1'b0} > IFG_FLOOR) ? {ifg_delay, 1'b0} : IFG_FLOOR;

    assign crc_init = (state == ST_IDLE);
    assign crc_valid = (state == ST_DATA) || (state == ST_PAD);

    always_comb begin
        mii_tx = '0;
        case (state)
            ST_PREAMBLE: begin
                mii_tx.en = 1'b1;
                mii_tx.d = (cnt == 4'd15) ? SFD_NIBBLE : PREAMBLE_NIBBLE;
            end
            ST_DATA: begin
                mii_tx.en = 1'b1;
                // Low nibble goes out first
                mii_tx.d = phase ? data_reg[7:4] : data_reg[3:0];
            end
            ST_PAD: begin
                mii_tx.en = 1'b1;
            end
            ST_FCS: begin
                mii_tx.en = 1'b1;
                mii_tx.d = ~crc[{cnt[2:0], 2'b00} +: 4];
                mii_tx.er = user_reg;
            end
            default: begin
            end
        endcase
    end

    eth_crc32 u_crc (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .init         (crc_init),
        .nibble_valid (crc_valid),
        .nibble       (mii_tx.d),
        .crc          (crc)
    );

    always_ff @(posedge logic_clk) begin
        if (take) begin
            data_reg <= s_axis.data;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state <= ST_IDLE;
            cnt <= '0;
            phase <= 1'b0;
            byte_cnt <= '0;
            gap_cnt <= '0;
            last_reg <= 1'b0;
            user_reg <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    cnt <= '0;
                    phase <= 1'b0;
                    byte_cnt <= '0;
                    if (take) begin
                        last_reg <= s_axis.last;
                        user_reg <= s_axis.user;
                        state <= ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd15) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    phase <= ~phase;
                    if (phase) begin
                        byte_cnt <= byte_cnt_inc;
                        if (!last_reg) begin
                            last_reg <= s_axis.last;
                            user_reg <= s_axis.user;
                        end else begin
                            cnt <= '0;
                            if (ENABLE_PADDING && byte_cnt_inc < PAD_BYTES) begin
                                state <= ST_PAD;
                            end else begin
                                state <= ST_FCS;
                            end
                        end
                    end
                end
                ST_PAD: begin
                    phase <= ~phase;
                    if (phase) begin
                        byte_cnt <= byte_cnt_inc;
                        if (byte_cnt_inc >= PAD_BYTES) begin
                            cnt <= '0;
                            state <= ST_FCS;
                        end
                    end
                end
                ST_FCS: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd7) begin
                        gap_cnt <= gap_len - 9'd1;
                        state <= ST_GAP;
                    end
                end
                default: begin
                    if (gap_cnt == 9'd0) begin
                        state <= ST_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt - 9'd1;
                    end
                end
            endcase
        end
    end

    // The TX FIFO only releases complete frames
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (state == ST_DATA && phase && !last_reg) |-> s_axis_valid)
        else $error("s_axis_valid dropped inside a frame");

endmodule

//--- eth_mac_pkg.sv
package eth_mac_pkg;

    // One byte of a user stream
    typedef struct packed {
        logic [7:0] data;
        // Final byte of the frame
        logic       last;
        // Bad frame when set on the last byte
        logic       user;
    } axis_byte_t;

    // One MII transfer
    typedef struct packed {
        logic [3:0] d;
        logic       en;
        logic       er;
    } mii_nibble_t;

    // Single cycle FIFO event pulses
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } fifo_status_t;

    typedef struct packed {
        fifo_status_t tx_fifo;
        logic         rx_error_bad_frame;
        logic         rx_error_bad_fcs;
        fifo_status_t rx_fifo;
    } mac_status_t;

    localparam logic [3:0] PREAMBLE_NIBBLE = 4'h5;
    localparam logic [3:0] SFD_NIBBLE = 4'hd;

    // Reflected CRC-32 as used by Ethernet
    localparam logic [31:0] CRC_POLY = 32'hedb88320;
    localparam logic [31:0] CRC_INIT = 32'hffffffff;
    // Register value once a good frame and its FCS are folded in
    localparam logic [31:0] CRC_RESIDUE = 32'hdebb20e3;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_eth_mac_mii_fifo \
    -f compile.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    exit 0
fi
exit 1

//--- tb_eth_mac_mii_fifo.sv
`timescale 1ns/1ps

module tb_eth_mac_mii_fifo;
    import eth_mac_pkg::*;

    localparam int MIN_FRAME_LENGTH = 64;
    localparam int PAD_LEN = MIN_FRAME_LENGTH - 4;
    // Preamble and SFD nibbles ahead of the data
    localparam int HEAD_NIBBLES = 16;
    localparam int CORRUPT_AT = 40;
    localparam int TX_GOOD = 0;
    localparam int TX_BAD = 1;
    localparam int RX_GOOD = 2;
    localparam int RX_BAD = 3;
    localparam int RX_OVF = 4;
    localparam int FCS_ERR = 5;
    localparam int FRAME_ERR = 6;

    logic        logic_clk;
    logic        logic_rst;
    axis_byte_t  tx_axis;
    logic        tx_axis_valid;
    logic        tx_axis_ready;
    axis_byte_t  rx_axis;
    logic        rx_axis_valid;
    logic        rx_axis_ready;
    mii_nibble_t mii_tx;
    mii_nibble_t mii_rx = '0;
    logic [7:0]  ifg_delay;
    mac_status_t status;

    int         errors;
    int         tests_run;
    int         tests_failed;
    logic [7:0] exp_data [4096];
    logic       exp_last [4096];
    int         exp_wr;
    int         exp_rd;
    logic [7:0] exp_data_cur;
    logic       exp_last_cur;
    int         nib_cnt;
    int         gap_cnt;
    int         min_gap;
    logic       frame_seen;
    logic       tx_silent;
    logic [1:0] corrupt_mode;
    int         counts [7];

    initial logic_clk = 1'b0;
    always #10 logic_clk = ~logic_clk;

    eth_mac_mii_fifo #(
        .MIN_FRAME_LENGTH  (MIN_FRAME_LENGTH),
        .ENABLE_PADDING    (1'b1),
        .TX_FIFO_DEPTH     (256),
        .RX_FIFO_DEPTH     (256),
        .RX_DROP_WHEN_FULL (1'b1)
    ) u_eth_mac_mii_fifo (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .tx_axis       (tx_axis),
        .tx_axis_valid (tx_axis_valid),
        .tx_axis_ready (tx_axis_ready),
        .rx_axis       (rx_axis),
        .rx_axis_valid (rx_axis_valid),
        .rx_axis_ready (rx_axis_ready),
        .mii_tx        (mii_tx),
        .mii_rx        (mii_rx),
        .ifg_delay     (ifg_delay),
        .status        (status)
    );

    assign exp_data_cur = exp_data[exp_rd % 4096];
    assign exp_last_cur = exp_last[exp_rd % 4096];
    assign min_gap = (2 * int'(ifg_delay) > 24) ? 2 * int'(ifg_delay) : 24;

    // Line monitor, event counters, scoreboard pop and MII loopback
    always @(posedge logic_clk) begin
        if (logic_rst) begin
            nib_cnt <= 0;
            gap_cnt <= 0;
            frame_seen <= 1'b0;
            exp_rd <= 0;
            mii_rx <= '0;
            for (int i = 0; i < 7; i++) begin
                counts[i] <= 0;
            end
        end else begin
            if (mii_tx.en) begin
                nib_cnt <= nib_cnt + 1;
                gap_cnt <= 0;
                frame_seen <= 1'b1;
            end else begin
                nib_cnt <= 0;
                gap_cnt <= gap_cnt + 1;
            end
            if (status.tx_fifo.good_frame) counts[TX_GOOD] <= counts[TX_GOOD] + 1;
            if (status.tx_fifo.bad_frame) counts[TX_BAD] <= counts[TX_BAD] + 1;
            if (status.rx_fifo.good_frame) counts[RX_GOOD] <= counts[RX_GOOD] + 1;
            if (status.rx_fifo.bad_frame) counts[RX_BAD] <= counts[RX_BAD] + 1;
            if (status.rx_fifo.overflow) counts[RX_OVF] <= counts[RX_OVF] + 1;
            if (status.rx_error_bad_fcs) counts[FCS_ERR] <= counts[FCS_ERR] + 1;
            if (status.rx_error_bad_frame) counts[FRAME_ERR] <= counts[FRAME_ERR] + 1;
            if (rx_axis_valid && rx_axis_ready && exp_rd != exp_wr) begin
                exp_rd <= exp_rd + 1;
            end
            mii_rx <= mii_tx;
            if (mii_tx.en && nib_cnt == CORRUPT_AT) begin
                if (corrupt_mode == 2'd1) mii_rx.d <= ~mii_tx.d;
                if (corrupt_mode == 2'd2) mii_rx.er <= 1'b1;
            end
        end
    end

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (rx_axis_valid && rx_axis_ready) |-> (exp_rd != exp_wr))
        else begin
            $display("Unexpected byte came out on rx_axis");
            errors++;
        end

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (rx_axis_valid && rx_axis_ready && exp_rd != exp_wr) |-> (rx_axis.data == exp_data_cur))
        else begin
            $display("** Error: rx_axis.data = %h, expected %h",
                $sampled(rx_axis.data), $sampled(exp_data_cur));
            errors++;
        end

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (rx_axis_valid && rx_axis_ready && exp_rd != exp_wr) |-> (rx_axis.last == exp_last_cur))
        else begin
            $display("** Error: rx_axis.last = %h, expected %h",
                $sampled(rx_axis.last), $sampled(exp_last_cur));
            errors++;
        end

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (rx_axis_valid && rx_axis_ready) |-> !rx_axis.user)
        else begin
            $display("** Error: rx_axis.user = %h, expected %h", 1'b1, 1'b0);
            errors++;
        end

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (mii_tx.en && nib_cnt < 15) |-> (mii_tx.d == PREAMBLE_NIBBLE))
        else begin
            $display("** Error: mii_tx.d = %h, expected %h", $sampled(mii_tx.d), PREAMBLE_NIBBLE);
            errors++;
        end

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (mii_tx.en && nib_cnt == 15) |-> (mii_tx.d == SFD_NIBBLE))
        else begin
            $display("** Error: mii_tx.d = %h, expected %h", $sampled(mii_tx.d), SFD_NIBBLE);
            errors++;
        end

    assert property (@(posedge logic_clk) disable iff (logic_rst) mii_tx.en |-> !mii_tx.er)
        else begin
            $display("** Error: mii_tx.er = %h, expected %h", 1'b1, 1'b0);
            errors++;
        end

    // TX FIFO stalls the user instead of dropping
    assert property (@(posedge logic_clk) disable iff (logic_rst) !status.tx_fifo.overflow)
        else begin
            $display("** Error: status.tx_fifo.overflow = %h, expected %h", 1'b1, 1'b0);
            errors++;
        end

    // Every frame is padded up to the minimum length plus FCS
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        $fell(mii_tx.en) |-> (nib_cnt >= HEAD_NIBBLES + 2 * PAD_LEN + 8))
        else begin
            $display("** Error: mii_tx frame nibbles = %h, expected at least %h",
                $sampled(nib_cnt), HEAD_NIBBLES + 2 * PAD_LEN + 8);
            errors++;
        end

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        ($rose(mii_tx.en) && frame_seen) |-> (gap_cnt >= min_gap))
        else begin
            $display("** Error: mii_tx gap = %h, expected at least %h",
                $sampled(gap_cnt), $sampled(min_gap));
            errors++;
        end

    assert property (@(posedge logic_clk) disable iff (logic_rst) tx_silent |-> !mii_tx.en)
        else begin
            $display("A dropped frame was sent on mii_tx");
            errors++;
        end

    task automatic push_expected(input logic [7:0] b, input logic l);
        exp_data[exp_wr % 4096] = b;
        exp_last[exp_wr % 4096] = l;
        exp_wr++;
    endtask

    task automatic send_frame(input int len, input logic bad, input logic comes_back);
        int padded;
        int t;
        logic [7:0] b;
        padded = (len < PAD_LEN) ? PAD_LEN : len;
        for (int i = 0; i < len; i++) begin
            b = 8'($urandom);
            tx_axis <= '{data: b, last: (i == len - 1), user: bad && (i == len - 1)};
            tx_axis_valid <= 1'b1;
            if (comes_back) push_expected(b, i == padded - 1);
            t = 0;
            do begin
                @(posedge logic_clk);
                t++;
            end while (!tx_axis_ready && t < 5000);
            if (!tx_axis_ready) begin
                $display("tx_axis_ready stayed low, byte not accepted");
                errors++;
            end
        end
        if (comes_back) begin
            for (int i = len; i < padded; i++) begin
                push_expected(8'h00, i == padded - 1);
            end
        end
        tx_axis_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_rd != exp_wr && t < 20000) begin
            @(posedge logic_clk);
            t++;
        end
        if (exp_rd != exp_wr) begin
            $display("Expected frame data never arrived on rx_axis");
            errors++;
        end
    endtask

    task automatic wait_count(input int which, input int target, input string what);
        int t;
        t = 0;
        while (counts[which] < target && t < 20000) begin
            @(posedge logic_clk);
            t++;
        end
        if (counts[which] < target) begin
            $display("Timed out waiting for %s", what);
            errors++;
        end
    endtask

    task automatic expect_count(input int which, input int target, input string what);
        assert (counts[which] == target)
        else begin
            $display("** Error: %s count = %h, expected %h", what, counts[which], target);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    initial begin
        int e;
        void'($urandom(32'hdd3b));
        logic_rst = 1'b1;
        tx_axis = '0;
        tx_axis_valid = 1'b0;
        rx_axis_ready = 1'b0;
        ifg_delay = 8'd12;
        tx_silent = 1'b0;
        corrupt_mode = 2'd0;
        exp_wr = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (4) @(posedge logic_clk);
        logic_rst <= 1'b0;
        @(posedge logic_clk);
        rx_axis_ready <= 1'b1;

        e = errors;
        send_frame(60 + int'($urandom % 141), 1'b0, 1'b1);
        wait_count(RX_GOOD, 1, "RX good frame");
        wait_drain();
        repeat (100) @(posedge logic_clk);
        expect_count(TX_GOOD, 1, "status.tx_fifo.good_frame");
        expect_count(RX_GOOD, 1, "status.rx_fifo.good_frame");
        report_test("good frame loopback", e);

        e = errors;
        send_frame(20, 1'b0, 1'b1);
        wait_count(RX_GOOD, 2, "padded frame");
        wait_drain();
        repeat (100) @(posedge logic_clk);
        report_test("line format and padding", e);

        e = errors;
        tx_silent <= 1'b1;
        send_frame(50, 1'b1, 1'b0);
        wait_count(TX_BAD, 1, "status.tx_fifo.bad_frame");
        repeat (400) @(posedge logic_clk);
        tx_silent <= 1'b0;
        expect_count(TX_GOOD, 2, "status.tx_fifo.good_frame");
        report_test("tx bad frame drop", e);

        e = errors;
        corrupt_mode <= 2'd1;
        send_frame(80, 1'b0, 1'b0);
        wait_count(FCS_ERR, 1, "status.rx_error_bad_fcs");
        wait_count(RX_BAD, 1, "status.rx_fifo.bad_frame");
        repeat (100) @(posedge logic_clk);
        corrupt_mode <= 2'd2;
        send_frame(80, 1'b0, 1'b0);
        wait_count(FRAME_ERR, 1, "status.rx_error_bad_frame");
        wait_count(RX_BAD, 2, "status.rx_fifo.bad_frame");
        repeat (100) @(posedge logic_clk);
        corrupt_mode <= 2'd0;
        expect_count(RX_GOOD, 2, "status.rx_fifo.good_frame");
        expect_count(FCS_ERR, 1, "status.rx_error_bad_fcs");
        expect_count(FRAME_ERR, 1, "status.rx_error_bad_frame");
        report_test("rx errors", e);

        e = errors;
        rx_axis_ready <= 1'b0;
        send_frame(100, 1'b0, 1'b1);
        send_frame(100, 1'b0, 1'b1);
        send_frame(100, 1'b0, 1'b0);
        wait_count(RX_OVF, 1, "status.rx_fifo.overflow");
        rx_axis_ready <= 1'b1;
        wait_drain();
        repeat (100) @(posedge logic_clk);
        expect_count(RX_GOOD, 4, "status.rx_fifo.good_frame");
        expect_count(RX_OVF, 1, "status.rx_fifo.overflow");
        report_test("rx back-pressure", e);

        e = errors;
        ifg_delay <= 8'd20;
        repeat (5) @(posedge logic_clk);
        send_frame(70, 1'b0, 1'b1);
        send_frame(70, 1'b0, 1'b1);
        wait_drain();
        repeat (100) @(posedge logic_clk);
        ifg_delay <= 8'd5;
        repeat (5) @(posedge logic_clk);
        send_frame(70, 1'b0, 1'b1);
        send_frame(70, 1'b0, 1'b1);
        wait_drain();
        repeat (100) @(posedge logic_clk);
        report_test("inter-frame gap", e);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
